// ==== hw/fabric_pkg.sv ====
package fabric_pkg;

  localparam int LUT_INPUTS = 4;
  localparam int LUT_SIZE   = 1 << LUT_INPUTS;
  localparam int NUM_SIDES  = 4;  // east 0, south 1, west 2, north 3
  localparam int CLB_IWIDTH = 6;  // 4 lut inputs, rst, ce
  localparam int CLB_OWIDTH = 2;  // {ff, comb}

  localparam int CLB_RST_PIN = 4;
  localparam int CLB_CE_PIN  = 5;

  typedef logic [LUT_SIZE-1:0] lut_t;
  typedef logic [1:0]          sb_sel_t;
  typedef logic [3:0]          pin_sel_t;
  typedef logic [2:0]          ctl_sel_t;  // {enable, side}

  localparam sb_sel_t  SB_OFF        = 2'd0;
  localparam pin_sel_t CB_TRACK_PASS = 4'd0;  // straight through the box
  localparam pin_sel_t CB_PIN_OFF    = 4'd0;

  // four truth tables, then rst select, then ce select
  localparam int LB_CFG_SIZE = NUM_SIDES * LUT_SIZE + 2 * $bits(ctl_sel_t);

  typedef enum logic {
    CFG_IDLE,
    CFG_SHIFT
  } cfg_state_t;

endpackage

// ==== hw/cfg_chain.sv ====
`timescale 1ns/1ps

module cfg_chain #(
  parameter int CFG_SIZE = 265,
  parameter int ID_WIDTH = 3,
  parameter int ID       = 5
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                cfg_in_start,
  input  logic                cfg_bit_in,
  output logic                cfg_out_start,
  output logic                cfg_bit_out,
  output logic [CFG_SIZE-1:0] cfg
);

  import fabric_pkg::*;

  localparam int CNT_W = $clog2(CFG_SIZE + 1);

  cfg_state_t          state;
  logic [CNT_W-1:0]    bit_cnt;
  logic [CFG_SIZE-1:0] frame;
  logic                frame_done;
  logic                id_match;

  assign id_match = (frame[ID_WIDTH-1:0] == ID_WIDTH'(ID));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= CFG_IDLE;
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        CFG_IDLE: begin
          if (cfg_in_start) begin
            state   <= CFG_SHIFT;
            bit_cnt <= '0;
          end
        end
        CFG_SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(CFG_SIZE - 1)) begin  // last frame bit
            state      <= CFG_IDLE;
            frame_done <= 1'b1;
          end
        end
        default: state <= CFG_IDLE;
      endcase
    end
  end

  // lsb first, so shift toward bit 0
  always_ff @(posedge clk) begin
    if (state == CFG_SHIFT) begin
      frame <= {cfg_bit_in, frame[CFG_SIZE-1:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '0;
    end else if (frame_done && id_match) begin
      cfg <= frame;  // frame for another tile is ignored
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_out_start <= 1'b0;
      cfg_bit_out   <= 1'b0;
    end else begin
      cfg_out_start <= cfg_in_start;  // next tile in chain
      cfg_bit_out   <= cfg_bit_in;
    end
  end

  a_no_start_in_frame: assert property (
    @(posedge clk) disable iff (rst)
    (state == CFG_SHIFT) |-> !$rose(cfg_in_start)
  );

endmodule

// ==== hw/switch_box.sv ====
`timescale 1ns/1ps

module switch_box #(
  parameter int CHN_WIDTH = 4
) (
  input  logic [CHN_WIDTH-1:0] north_in,
  input  logic [CHN_WIDTH-1:0] east_in,
  input  logic [CHN_WIDTH-1:0] south_in,
  input  logic [CHN_WIDTH-1:0] west_in,
  output logic [CHN_WIDTH-1:0] north_out,
  output logic [CHN_WIDTH-1:0] east_out,
  output logic [CHN_WIDTH-1:0] south_out,
  output logic [CHN_WIDTH-1:0] west_out,
  input  fabric_pkg::sb_sel_t [fabric_pkg::NUM_SIDES*CHN_WIDTH-1:0] cfg
);

  import fabric_pkg::*;

  logic [CHN_WIDTH-1:0] side_in  [NUM_SIDES];
  logic [CHN_WIDTH-1:0] side_out [NUM_SIDES];

  assign side_in[0] = east_in;
  assign side_in[1] = south_in;
  assign side_in[2] = west_in;
  assign side_in[3] = north_in;

  assign east_out  = side_out[0];
  assign south_out = side_out[1];
  assign west_out  = side_out[2];
  assign north_out = side_out[3];

  for (genvar s = 0; s < NUM_SIDES; s++) begin : g_side
    for (genvar i = 0; i < CHN_WIDTH; i++) begin : g_track
      logic [2:0] cand;  // clockwise neighbours, 1 step first
      sb_sel_t    code;

      assign code = cfg[s*CHN_WIDTH+i];
      assign cand = {side_in[(s+3)%NUM_SIDES][i],
                     side_in[(s+2)%NUM_SIDES][i],
                     side_in[(s+1)%NUM_SIDES][i]};

      assign side_out[s][i] = (code == SB_OFF) ? 1'b0 : cand[code - 2'd1];
    end
  end

endmodule

// ==== hw/conn_box.sv ====
`timescale 1ns/1ps

module conn_box #(
  parameter int CHN_WIDTH = 4
) (
  input  logic [fabric_pkg::CLB_OWIDTH-1:0] clb0_output,
  input  logic [fabric_pkg::CLB_OWIDTH-1:0] clb1_output,
  output logic [fabric_pkg::CLB_IWIDTH-1:0] clb0_input,
  output logic [fabric_pkg::CLB_IWIDTH-1:0] clb1_input,
  input  logic [CHN_WIDTH-1:0]              single0_in,
  input  logic [CHN_WIDTH-1:0]              single1_in,
  output logic [CHN_WIDTH-1:0]              single0_out,
  output logic [CHN_WIDTH-1:0]              single1_out,
  input  fabric_pkg::pin_sel_t [2*CHN_WIDTH+2*fabric_pkg::CLB_IWIDTH-1:0] cfg
);

  import fabric_pkg::*;

  localparam int SNG1_BASE = CHN_WIDTH;
  localparam int CLB0_BASE = 2 * CHN_WIDTH;
  localparam int CLB1_BASE = CLB0_BASE + CLB_IWIDTH;

  logic [2*CLB_OWIDTH-1:0] clb_outs;
  logic [2*CHN_WIDTH-1:0]  tracks;

  assign clb_outs = {clb1_output, clb0_output};
  assign tracks   = {single1_in, single0_in};

  function automatic logic pick_track(input pin_sel_t code, input logic pass_bit,
                                      input logic [2*CLB_OWIDTH-1:0] outs);
    logic res;
    if (code == CB_TRACK_PASS) res = pass_bit;
    else if (int'(code) <= 2 * CLB_OWIDTH) res = outs[int'(code) - 1];
    else res = 1'b0;
    return res;
  endfunction

  function automatic logic pick_pin(input pin_sel_t code, input logic [2*CHN_WIDTH-1:0] trk,
                                    input logic [CLB_OWIDTH-1:0] opp);
    logic res;
    if (code == CB_PIN_OFF) res = 1'b0;
    else if (int'(code) <= 2 * CHN_WIDTH) res = trk[int'(code) - 1];
    else if (int'(code) <= 2 * CHN_WIDTH + CLB_OWIDTH) res = opp[int'(code) - 2*CHN_WIDTH - 1];
    else res = 1'b0;
    return res;
  endfunction

  for (genvar i = 0; i < CHN_WIDTH; i++) begin : g_trk
    assign single0_out[i] = pick_track(cfg[i], single1_in[i], clb_outs);
    assign single1_out[i] = pick_track(cfg[SNG1_BASE+i], single0_in[i], clb_outs);
  end

  // each side's pins can also see the logic block across the channel
  for (genvar j = 0; j < CLB_IWIDTH; j++) begin : g_pin
    assign clb0_input[j] = pick_pin(cfg[CLB0_BASE+j], tracks, clb1_output);
    assign clb1_input[j] = pick_pin(cfg[CLB1_BASE+j], tracks, clb0_output);
  end

endmodule

// ==== hw/logic_block.sv ====
`timescale 1ns/1ps

module logic_block (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic [fabric_pkg::NUM_SIDES*fabric_pkg::CLB_IWIDTH-1:0] pins_in,
  input  logic [fabric_pkg::LB_CFG_SIZE-1:0]                  cfg,
  output logic [fabric_pkg::NUM_SIDES*fabric_pkg::CLB_OWIDTH-1:0] pins_out
);

  import fabric_pkg::*;

  localparam int RST_SEL_POS = NUM_SIDES * LUT_SIZE;
  localparam int CE_SEL_POS  = RST_SEL_POS + $bits(ctl_sel_t);

  lut_t                 lut_tab [NUM_SIDES];
  ctl_sel_t             rst_sel;
  ctl_sel_t             ce_sel;
  logic [NUM_SIDES-1:0] lut_out;
  logic [NUM_SIDES-1:0] ff_q;
  logic [NUM_SIDES-1:0] rst_cand;
  logic [NUM_SIDES-1:0] ce_cand;
  logic                 fab_rst;
  logic                 fab_ce;

  for (genvar k = 0; k < NUM_SIDES; k++) begin : g_lut
    logic [LUT_INPUTS-1:0] lut_in;

    assign lut_tab[k]  = cfg[k*LUT_SIZE +: LUT_SIZE];
    assign lut_in      = pins_in[k*CLB_IWIDTH +: LUT_INPUTS];
    assign lut_out[k]  = lut_tab[k][lut_in];
    assign rst_cand[k] = pins_in[k*CLB_IWIDTH + CLB_RST_PIN];
    assign ce_cand[k]  = pins_in[k*CLB_IWIDTH + CLB_CE_PIN];

    assign pins_out[k*CLB_OWIDTH +: CLB_OWIDTH] = {ff_q[k], lut_out[k]};
  end

  assign rst_sel = cfg[RST_SEL_POS +: $bits(ctl_sel_t)];
  assign ce_sel  = cfg[CE_SEL_POS +: $bits(ctl_sel_t)];

  // disabled control reads as 0
  assign fab_rst = rst_sel[2] & rst_cand[rst_sel[1:0]];
  assign fab_ce  = ce_sel[2] & ce_cand[ce_sel[1:0]];

  always_ff @(posedge clk) begin
    if (rst || fab_rst) begin
      ff_q <= '0;
    end else if (fab_ce) begin
      ff_q <= lut_out;  // all four share ce
    end
  end

  a_pins_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(pins_out)
  );

endmodule

// ==== hw/fabric_tile.sv ====
`timescale 1ns/1ps

module fabric_tile #(
  parameter int CHN_WIDTH = 4,
  parameter int ID_WIDTH  = 3,
  parameter int ID        = 5
) (
  input  logic [CHN_WIDTH-1:0]              sb_north_in,
  input  logic [CHN_WIDTH-1:0]              sb_east_in,
  output logic [CHN_WIDTH-1:0]              sb_north_out,
  output logic [CHN_WIDTH-1:0]              sb_east_out,

  input  logic [CHN_WIDTH-1:0]              cb_e_single1_in,
  output logic [CHN_WIDTH-1:0]              cb_e_single1_out,
  input  logic [fabric_pkg::CLB_OWIDTH-1:0] cb_e_clb1_output,
  output logic [fabric_pkg::CLB_IWIDTH-1:0] cb_e_clb1_input,

  input  logic [CHN_WIDTH-1:0]              cb_n_single1_in,
  output logic [CHN_WIDTH-1:0]              cb_n_single1_out,
  input  logic [fabric_pkg::CLB_OWIDTH-1:0] cb_n_clb1_output,
  output logic [fabric_pkg::CLB_IWIDTH-1:0] cb_n_clb1_input,

  input  logic [fabric_pkg::CLB_IWIDTH-1:0] clb_south_in,
  input  logic [fabric_pkg::CLB_IWIDTH-1:0] clb_west_in,
  output logic [fabric_pkg::CLB_OWIDTH-1:0] clb_south_out,
  output logic [fabric_pkg::CLB_OWIDTH-1:0] clb_west_out,

  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cfg_in_start,
  input  logic                              cfg_bit_in,
  output logic                              cfg_out_start,
  output logic                              cfg_bit_out
);

  import fabric_pkg::*;

  localparam int SB_CFG_SIZE = NUM_SIDES * CHN_WIDTH * $bits(sb_sel_t);
  localparam int CB_CFG_SIZE = (2 * CHN_WIDTH + 2 * CLB_IWIDTH) * $bits(pin_sel_t);

  // frame layout, id first
  localparam int SB_OFFSET   = ID_WIDTH;
  localparam int CB_E_OFFSET = SB_OFFSET + SB_CFG_SIZE;
  localparam int CB_N_OFFSET = CB_E_OFFSET + CB_CFG_SIZE;
  localparam int LB_OFFSET   = CB_N_OFFSET + CB_CFG_SIZE;
  localparam int CFG_SIZE    = LB_OFFSET + LB_CFG_SIZE;

  logic [CFG_SIZE-1:0]              cfg;
  logic [SB_CFG_SIZE-1:0]           sb_cfg;
  logic [CB_CFG_SIZE-1:0]           cb_e_cfg;
  logic [CB_CFG_SIZE-1:0]           cb_n_cfg;
  logic [LB_CFG_SIZE-1:0]           lb_cfg;

  logic [CHN_WIDTH-1:0]             cb_e_single0_in, cb_e_single0_out;
  logic [CHN_WIDTH-1:0]             cb_n_single0_in, cb_n_single0_out;
  logic [CLB_IWIDTH-1:0]            cb_e_clb0_input, cb_n_clb0_input;
  logic [CLB_OWIDTH-1:0]            cb_e_clb0_output, cb_n_clb0_output;
  logic [NUM_SIDES*CLB_IWIDTH-1:0]  clb_pins_in;
  logic [NUM_SIDES*CLB_OWIDTH-1:0]  clb_pins_out;

  assign sb_cfg   = cfg[SB_OFFSET +: SB_CFG_SIZE];
  assign cb_e_cfg = cfg[CB_E_OFFSET +: CB_CFG_SIZE];
  assign cb_n_cfg = cfg[CB_N_OFFSET +: CB_CFG_SIZE];
  assign lb_cfg   = cfg[LB_OFFSET +: LB_CFG_SIZE];

  // sides ordered east, south, west, north
  assign clb_pins_in = {cb_n_clb0_input, clb_west_in, clb_south_in, cb_e_clb0_input};
  assign {cb_n_clb0_output, clb_west_out, clb_south_out, cb_e_clb0_output} = clb_pins_out;

  cfg_chain #(
    .CFG_SIZE (CFG_SIZE),
    .ID_WIDTH (ID_WIDTH),
    .ID       (ID)
  ) cfg_blk (
    .clk           (clk),
    .rst           (rst),
    .cfg_in_start  (cfg_in_start),
    .cfg_bit_in    (cfg_bit_in),
    .cfg_out_start (cfg_out_start),
    .cfg_bit_out   (cfg_bit_out),
    .cfg           (cfg)
  );

  switch_box #(
    .CHN_WIDTH (CHN_WIDTH)
  ) sb (
    .north_in  (sb_north_in),
    .east_in   (sb_east_in),
    .south_in  (cb_e_single0_out),  // east box segment 0
    .west_in   (cb_n_single0_out),  // north box segment 0
    .north_out (sb_north_out),
    .east_out  (sb_east_out),
    .south_out (cb_e_single0_in),
    .west_out  (cb_n_single0_in),
    .cfg       (sb_cfg)
  );

  conn_box #(
    .CHN_WIDTH (CHN_WIDTH)
  ) cb_e (
    .clb0_output (cb_e_clb0_output),
    .clb1_output (cb_e_clb1_output),
    .clb0_input  (cb_e_clb0_input),
    .clb1_input  (cb_e_clb1_input),
    .single0_in  (cb_e_single0_in),
    .single1_in  (cb_e_single1_in),
    .single0_out (cb_e_single0_out),
    .single1_out (cb_e_single1_out),
    .cfg         (cb_e_cfg)
  );

  conn_box #(
    .CHN_WIDTH (CHN_WIDTH)
  ) cb_n (
    .clb0_output (cb_n_clb0_output),
    .clb1_output (cb_n_clb1_output),
    .clb0_input  (cb_n_clb0_input),
    .clb1_input  (cb_n_clb1_input),
    .single0_in  (cb_n_single0_in),
    .single1_in  (cb_n_single1_in),
    .single0_out (cb_n_single0_out),
    .single1_out (cb_n_single1_out),
    .cfg         (cb_n_cfg)
  );

  logic_block lb (
    .clk      (clk),
    .rst      (rst),
    .pins_in  (clb_pins_in),
    .cfg      (lb_cfg),
    .pins_out (clb_pins_out)
  );

endmodule

// ==== sim/tb_fabric_tile.sv ====
`timescale 1ns/1ps

module tb_fabric_tile;

  localparam int ID       = 5;
  localparam int SB_POS   = 3;  // frame field offsets, id at 0
  localparam int CBE_POS  = SB_POS + 32;
  localparam int CBN_POS  = CBE_POS + 80;
  localparam int LB_POS   = CBN_POS + 80;
  localparam int CFG_SIZE = LB_POS + 70;
  localparam int NUM_ROWS = 18;
  localparam longint WATCHDOG_NS = longint'(NUM_ROWS) * (CFG_SIZE + 20) * 8;

  logic       clk = 1'b0;
  logic       rst;
  logic       cfg_in_start, cfg_bit_in, cfg_out_start, cfg_bit_out;
  logic [3:0] sb_north_in, sb_east_in, sb_north_out, sb_east_out;
  logic [3:0] cb_e_single1_in, cb_e_single1_out, cb_n_single1_in, cb_n_single1_out;
  logic [1:0] cb_e_clb1_output, cb_n_clb1_output, clb_south_out, clb_west_out;
  logic [5:0] cb_e_clb1_input, cb_n_clb1_input, clb_south_in, clb_west_in;

  // stimulus and expected table, one row per test step
  logic        do_load  [NUM_ROWS];
  logic [2:0]  row_id   [NUM_ROWS];
  logic [31:0] row_sb   [NUM_ROWS];
  logic [79:0] row_cbe  [NUM_ROWS];
  logic [79:0] row_cbn  [NUM_ROWS];
  logic [69:0] row_lb   [NUM_ROWS];
  logic [31:0] row_in   [NUM_ROWS];
  logic [31:0] row_exp  [NUM_ROWS];
  logic        row_ffok [NUM_ROWS];

  logic [31:0] act_sb;  // reference model state
  logic [79:0] act_cbe, act_cbn;
  logic [69:0] act_lb;
  logic [3:0]  ff_model;
  logic        ff_known;
  integer      seed;
  int          cur_row;

  fabric_tile uut (.*);

  always #4 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h (row %0d)", name, got, exp, cur_row);
      $display("*** TEST FAILED ***");
      $fatal(1, "output mismatch");
    end
  endtask

  function automatic logic [15:0] switch_ref(input logic [31:0] codes, input logic [15:0] ins);
    logic [15:0] res;
    int          c;
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 4; i++) begin
        c = int'(codes[2*(4*s+i) +: 2]);
        res[4*s+i] = (c == 0) ? 1'b0 : ins[4*((s+c)%4) + i];  // c steps clockwise
      end
    end
    return res;
  endfunction

  function automatic logic track_ref(input logic [3:0] code, input logic pass,
                                     input logic [3:0] outs);
    if (code == 0) return pass;
    if (code <= 4) return outs[code-1];
    return 1'b0;
  endfunction

  function automatic logic pin_ref(input logic [3:0] code, input logic [7:0] trk,
                                   input logic [1:0] opp);
    if (code == 0) return 1'b0;
    if (code <= 8) return trk[code-1];
    if (code <= 10) return opp[code-9];
    return 1'b0;
  endfunction

  // returns {clb1_input, clb0_input, single1_out, single0_out}
  function automatic logic [19:0] cbox_ref(input logic [79:0] cfg, input logic [1:0] clb0_o,
                                           input logic [1:0] clb1_o, input logic [3:0] s0_in,
                                           input logic [3:0] s1_in);
    logic [19:0] res;
    for (int i = 0; i < 4; i++) begin
      res[i]   = track_ref(cfg[4*i +: 4], s1_in[i], {clb1_o, clb0_o});
      res[4+i] = track_ref(cfg[4*(4+i) +: 4], s0_in[i], {clb1_o, clb0_o});
    end
    for (int j = 0; j < 6; j++) begin
      res[8+j]  = pin_ref(cfg[4*(8+j) +: 4], {s1_in, s0_in}, clb1_o);
      res[14+j] = pin_ref(cfg[4*(14+j) +: 4], {s1_in, s0_in}, clb0_o);
    end
    return res;
  endfunction

  function automatic logic [79:0] random_box_cfg();
    logic [79:0] res;
    logic [3:0]  code;
    for (int n = 0; n < 20; n++) begin
      code = 4'($random(seed));
      if (n < 8 && code == 2) code = 4'd1;  // no ff bit onto tracks
      if (n >= 8 && n < 14) code = 4'd0;  // clb0 pins held low
      if (n >= 14 && code == 10) code = 4'd9;
      res[4*n +: 4] = code;
    end
    return res;
  endfunction

  task automatic fill_row(input int r, input logic load, input logic [2:0] id);
    do_load[r] = load;
    row_id[r]  = id;
    row_in[r]  = $random(seed);
    row_lb[r]  = 70'({$random(seed), $random(seed), $random(seed)});
    row_cbe[r] = random_box_cfg();
    row_cbn[r] = random_box_cfg();
    for (int n = 0; n < 16; n++) begin
      row_sb[r][2*n +: 2] = 2'((r + n/4 + n%4) % 4);  // every code over four rows
    end
  endtask

  task automatic model_row(input int r);
    logic [3:0]  n_in, e_in, e1_in, n1_in, comb;
    logic [1:0]  e_co, n_co;
    logic [5:0]  s_pins, w_pins;
    logic [5:0]  pins [4];
    logic [15:0] sbo;
    logic [19:0] cbe, cbn;
    logic [2:0]  rsel, csel;
    {n_in, e_in, e1_in, e_co, n1_in, n_co, s_pins, w_pins} = row_in[r];
    if (do_load[r]) begin
      ff_known = 1'b0;
      if (row_id[r] == ID) begin
        act_sb  = row_sb[r];
        act_cbe = row_cbe[r];
        act_cbn = row_cbn[r];
        act_lb  = row_lb[r];
      end
    end
    comb = '0;
    cbe  = '0;
    cbn  = '0;
    repeat (8) begin  // settle the routing loop
      sbo = switch_ref(act_sb, {n_in, cbn[3:0], cbe[3:0], e_in});
      cbe = cbox_ref(act_cbe, {ff_model[0], comb[0]}, e_co, sbo[7:4], e1_in);
      cbn = cbox_ref(act_cbn, {ff_model[3], comb[3]}, n_co, sbo[11:8], n1_in);
      pins[0] = cbe[13:8];
      pins[1] = s_pins;
      pins[2] = w_pins;
      pins[3] = cbn[13:8];
      for (int k = 0; k < 4; k++) comb[k] = act_lb[16*k + pins[k][3:0]];
    end
    row_exp[r]  = {sbo[15:12], sbo[3:0], cbe[7:4], cbe[19:14], cbn[7:4], cbn[19:14],
                   ff_model[1], comb[1], ff_model[2], comb[2]};
    row_ffok[r] = ff_known;
    rsel = act_lb[64 +: 3];
    csel = act_lb[67 +: 3];
    if (rsel[2] && pins[rsel[1:0]][4]) begin
      ff_model = '0;
      ff_known = 1'b1;
    end else if (csel[2] && pins[csel[1:0]][5]) begin
      ff_model = comb;
      ff_known = 1'b1;
    end
  endtask

  function automatic logic [CFG_SIZE-1:0] build_frame(input int r);
    logic [CFG_SIZE-1:0] f;
    f[0 +: 3]       = row_id[r];
    f[SB_POS +: 32] = row_sb[r];
    f[CBE_POS +: 80] = row_cbe[r];
    f[CBN_POS +: 80] = row_cbn[r];
    f[LB_POS +: 70] = row_lb[r];
    return f;
  endfunction

  // start pulse, CFG_SIZE bits, then two idle cycles for the commit
  task automatic shift_frame(input logic [CFG_SIZE-1:0] frame);
    logic ps, pb;
    for (int n = 0; n <= CFG_SIZE + 2; n++) begin
      ps = cfg_in_start;
      pb = cfg_bit_in;
      @(posedge clk);
      #1;
      compare_value("cfg_out_start", cfg_out_start, ps);
      compare_value("cfg_bit_out", cfg_bit_out, pb);
      cfg_in_start = (n == 0);
      cfg_bit_in   = (n >= 1 && n <= CFG_SIZE) ? frame[n-1] : 1'b0;
    end
  endtask

  task automatic check_row(input int r);
    logic [31:0] e;
    e = row_exp[r];
    compare_value("sb_north_out", sb_north_out, e[31:28]);
    compare_value("sb_east_out", sb_east_out, e[27:24]);
    compare_value("cb_e_single1_out", cb_e_single1_out, e[23:20]);
    compare_value("cb_e_clb1_input", cb_e_clb1_input, e[19:14]);
    compare_value("cb_n_single1_out", cb_n_single1_out, e[13:10]);
    compare_value("cb_n_clb1_input", cb_n_clb1_input, e[9:4]);
    compare_value("clb_south_out[0]", clb_south_out[0], e[2]);
    compare_value("clb_west_out[0]", clb_west_out[0], e[0]);
    if (row_ffok[r]) begin
      compare_value("clb_south_out[1]", clb_south_out[1], e[3]);
      compare_value("clb_west_out[1]", clb_west_out[1], e[1]);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all table rows were applied");
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

  initial begin
    seed = 49;
    rst = 1'b1;
    cfg_in_start = 1'b0;
    cfg_bit_in = 1'b0;
    {sb_north_in, sb_east_in, cb_e_single1_in, cb_e_clb1_output} = '0;
    {cb_n_single1_in, cb_n_clb1_output, clb_south_in, clb_west_in} = '0;

    fill_row(0, 1'b0, 3'(ID));  // config after reset
    fill_row(1, 1'b1, 3'(ID));
    fill_row(2, 1'b1, 3'd3);  // frame for another tile
    for (int r = 3; r < 10; r++) fill_row(r, 1'b1, 3'(ID));
    for (int r = 10; r < NUM_ROWS; r++) begin
      fill_row(r, r == 10, 3'(ID));
      row_lb[r][69:64] = 6'b110_101;  // ce from west pin 5, rst from south pin 4
      row_in[r][10] = (r == 10 || r == 15);
      row_in[r][5]  = (r % 2 == 1);
    end

    act_sb = '0;
    act_cbe = '0;
    act_cbn = '0;
    act_lb = '0;
    ff_model = '0;
    ff_known = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) model_row(r);

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    compare_value("cfg_out_start", cfg_out_start, 1'b0);
    compare_value("cfg_bit_out", cfg_bit_out, 1'b0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_row = r;
      if (do_load[r]) shift_frame(build_frame(r));
      {sb_north_in, sb_east_in, cb_e_single1_in, cb_e_clb1_output,
       cb_n_single1_in, cb_n_clb1_output, clb_south_in, clb_west_in} = row_in[r];
      #5;
      check_row(r);
      @(posedge clk);
      #1;
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== fabric_tile.f ====
hw/fabric_pkg.sv
hw/cfg_chain.sv
hw/switch_box.sv
hw/conn_box.sv
hw/logic_block.sv
hw/fabric_tile.sv
sim/tb_fabric_tile.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal --top-module tb_fabric_tile \
  -f fabric_tile.f -o tb_fabric_tile

out=$(./obj_dir/tb_fabric_tile || true)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1
